// File: src/spw_token_pkg.sv
package spw_token_pkg;

	// ------------------------------
	// Character field widths
	// ------------------------------
	localparam int CTRL_PAYLOAD_BITS = 2;
	localparam int DATA_PAYLOAD_BITS = 8;

	typedef logic [1:0] ctrl_code_t;
	typedef logic [7:0] data_byte_t;

	// Bit 8 set marks an end-of-packet marker
	typedef logic [8:0] char_word_t;

	// Low 6 bits are the time value, top 2 bits the control flags
	typedef logic [7:0] time_code_t;

	// ------------------------------
	// Control character codes
	// ------------------------------
	localparam ctrl_code_t CTRL_FCT = 2'd0;
	localparam ctrl_code_t CTRL_EOP = 2'd1;
	localparam ctrl_code_t CTRL_EEP = 2'd2;
	localparam ctrl_code_t CTRL_ESC = 2'd3;

	// FIFO encodings of the end markers
	localparam char_word_t CHAR_EOP = 9'h100;
	localparam char_word_t CHAR_EEP = 9'h101;

	// Deserializer FSM
	typedef enum logic [1:0]
	{
		WAIT_FIRST,
		GET_PARITY,
		GET_FLAG,
		GET_PAYLOAD
	} deser_state_t;

endpackage

// File: src/spw_bus_pkg.sv
package spw_bus_pkg;

	// Register map
	typedef logic [1:0] reg_addr_t;
	typedef logic [15:0] bus_word_t;

	localparam reg_addr_t REG_DATA      = 2'd0;
	localparam reg_addr_t REG_STATUS    = 2'd1;
	localparam reg_addr_t REG_TIME      = 2'd2;
	localparam reg_addr_t REG_FCT_COUNT = 2'd3;

	// Receive FIFO sizing, pointers carry one wrap bit
	localparam int FIFO_DEPTH     = 16;
	localparam int FIFO_ADDR_BITS = 4;
	typedef logic [FIFO_ADDR_BITS:0] fifo_ptr_t;

	// Status register bits
	localparam int ST_EMPTY      = 0;
	localparam int ST_FULL       = 1;
	localparam int ST_OVERFLOW   = 2;
	localparam int ST_PARITY_ERR = 3;
	localparam int ST_ESC_ERR    = 4;
	localparam int ST_GOT_NULL   = 5;

	typedef logic [7:0] fct_count_t;

endpackage

// File: src/ds_bit_sampler.sv
`timescale 1ns/1ps

module ds_bit_sampler
(
	input  logic negedge_clk,
	input  logic rx_resetn,
	input  logic rx_din,
	input  logic rx_sin,
	output logic bit_valid,
	output logic bit_value
);

	logic d_meta;
	logic d_sync;
	logic s_meta;
	logic s_sync;
	logic d_prev;
	logic s_prev;

	// Two-flop synchronizers, then compare D xor S against last cycle
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			d_meta    <= 1'b0;
			d_sync    <= 1'b0;
			s_meta    <= 1'b0;
			s_sync    <= 1'b0;
			d_prev    <= 1'b0;
			s_prev    <= 1'b0;
			bit_valid <= 1'b0;
			bit_value <= 1'b0;
		end
		else
		begin
			d_meta    <= rx_din;
			d_sync    <= d_meta;
			s_meta    <= rx_sin;
			s_sync    <= s_meta;
			d_prev    <= d_sync;
			s_prev    <= s_sync;
			// Any change of D xor S is a new bit
			bit_valid <= (d_sync ^ s_sync) != (d_prev ^ s_prev);
			bit_value <= d_sync;
		end
	end

	// Both lines moving together means a lost bit on the link
	ds_single_change_a: assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		!((d_sync != d_prev) && (s_sync != s_prev)))
		else $error("D and S changed in the same cycle");

endmodule

// File: src/token_deserializer.sv
`timescale 1ns/1ps

module token_deserializer
	import spw_token_pkg::*;
(
	input  logic       negedge_clk,
	input  logic       rx_resetn,
	input  logic       bit_valid,
	input  logic       bit_value,
	output logic       token_valid,
	output logic       token_is_data,
	output logic       parity_error,
	output data_byte_t token_payload
);

	deser_state_t state_q;
	logic [2:0]   bit_cnt_q;
	logic         prev_par_q;
	logic         is_data_q;
	logic         parity_bit_q;
	logic         par_err_q;
	data_byte_t   shift_q;
	data_byte_t   next_word;
	logic [2:0]   last_idx;
	logic         last_bit;

	// Payload arrives LSB first, each bit lands at its own index
	always_comb
	begin
		next_word = shift_q;
		next_word[bit_cnt_q] = bit_value;
	end

	assign last_idx = is_data_q ? 3'(DATA_PAYLOAD_BITS - 1) : 3'(CTRL_PAYLOAD_BITS - 1);
	assign last_bit = bit_valid && (state_q == GET_PAYLOAD) && (bit_cnt_q == last_idx);

	// ------------------------------
	// Character framing FSM
	// ------------------------------
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			state_q     <= WAIT_FIRST;
			bit_cnt_q   <= '0;
			prev_par_q  <= 1'b0;
			token_valid <= 1'b0;
		end
		else
		begin
			token_valid <= 1'b0;
			if (bit_valid)
			begin
				case (state_q)
					WAIT_FIRST:
					begin
						// Leading zero is the first parity bit, the 1 is the ESC flag
						if (bit_value)
						begin
							state_q   <= GET_PAYLOAD;
							bit_cnt_q <= '0;
						end
					end
					GET_PARITY:
					begin
						state_q <= GET_FLAG;
					end
					GET_FLAG:
					begin
						state_q   <= GET_PAYLOAD;
						bit_cnt_q <= '0;
					end
					GET_PAYLOAD:
					begin
						if (bit_cnt_q == last_idx)
						begin
							state_q     <= GET_PARITY;
							token_valid <= 1'b1;
							// Covered by the next character's parity bit
							prev_par_q  <= ^next_word;
						end
						else
						begin
							bit_cnt_q <= bit_cnt_q + 3'd1;
						end
					end
					default:
					begin
						state_q <= WAIT_FIRST;
					end
				endcase
			end
		end
	end

	// Character fields and token output
	always_ff @(posedge negedge_clk)
	begin
		if (bit_valid)
		begin
			case (state_q)
				WAIT_FIRST:
				begin
					is_data_q <= 1'b0;
					par_err_q <= 1'b0;
					shift_q   <= '0;
				end
				GET_PARITY:
				begin
					parity_bit_q <= bit_value;
				end
				GET_FLAG:
				begin
					// Flag is high for a control character
					is_data_q <= !bit_value;
					// Odd parity over previous payload, flag and parity bit
					par_err_q <= !(prev_par_q ^ bit_value ^ parity_bit_q);
					shift_q   <= '0;
				end
				GET_PAYLOAD:
				begin
					shift_q <= next_word;
				end
				default:
				begin
				end
			endcase
		end
		if (last_bit)
		begin
			token_is_data <= is_data_q;
			token_payload <= next_word;
			parity_error  <= par_err_q;
		end
	end

	// Shortest character is four bits long
	token_spacing_a: assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		token_valid |=> !token_valid)
		else $error("token_valid high in two consecutive cycles");

endmodule

// File: src/token_classifier.sv
`timescale 1ns/1ps

module token_classifier
	import spw_token_pkg::*;
	import spw_bus_pkg::*;
(
	input  logic       negedge_clk,
	input  logic       rx_resetn,
	input  logic       token_valid,
	input  logic       token_is_data,
	input  logic       parity_error,
	input  data_byte_t token_payload,
	output logic       char_push,
	output char_word_t char_data,
	output logic       tick_out,
	output time_code_t time_value,
	output fct_count_t fct_count,
	output logic       got_null,
	output logic       parity_err_flag,
	output logic       esc_err_flag,
	input  logic       clear_flags
);

	logic       esc_pending;
	ctrl_code_t ctrl;
	logic       is_fct;
	logic       is_esc;

	assign ctrl   = token_payload[CTRL_PAYLOAD_BITS-1:0];
	assign is_fct = !token_is_data && (ctrl == CTRL_FCT);
	assign is_esc = !token_is_data && (ctrl == CTRL_ESC);

	// ------------------------------
	// Escape resolution and flags
	// ------------------------------
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			esc_pending     <= 1'b0;
			char_push       <= 1'b0;
			tick_out        <= 1'b0;
			time_value      <= '0;
			fct_count       <= '0;
			got_null        <= 1'b0;
			parity_err_flag <= 1'b0;
			esc_err_flag    <= 1'b0;
		end
		else
		begin
			char_push <= 1'b0;
			tick_out  <= 1'b0;
			if (clear_flags)
			begin
				parity_err_flag <= 1'b0;
				esc_err_flag    <= 1'b0;
			end
			if (token_valid)
			begin
				if (parity_error)
				begin
					parity_err_flag <= 1'b1;
					esc_pending     <= 1'b0;
				end
				else if (esc_pending)
				begin
					esc_pending <= 1'b0;
					if (token_is_data)
					begin
						if (got_null)
						begin
							time_value <= token_payload;
							tick_out   <= 1'b1;
						end
					end
					else if (is_fct)
					begin
						got_null <= 1'b1;
					end
					else
					begin
						esc_err_flag <= 1'b1;
					end
				end
				else if (is_esc)
				begin
					esc_pending <= 1'b1;
				end
				else if (is_fct)
				begin
					// Everything before the first NULL is ignored
					if (got_null)
						fct_count <= fct_count + 8'd1;
				end
				else
				begin
					char_push <= got_null;
				end
			end
		end
	end

	// N-char byte or end marker, only sampled with char_push
	always_ff @(posedge negedge_clk)
	begin
		if (token_valid)
		begin
			if (token_is_data)
				char_data <= {1'b0, token_payload};
			else if (ctrl == CTRL_EEP)
				char_data <= CHAR_EEP;
			else
				char_data <= CHAR_EOP;
		end
	end

	push_after_null_a: assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		char_push |-> got_null)
		else $error("Character pushed before first NULL");

endmodule

// File: src/rx_fifo.sv
`timescale 1ns/1ps

module rx_fifo
	import spw_token_pkg::*;
	import spw_bus_pkg::*;
(
	input  logic       negedge_clk,
	input  logic       rx_resetn,
	input  logic       push,
	input  logic       pop,
	input  char_word_t wdata,
	output char_word_t rdata,
	output logic       empty,
	output logic       full,
	output logic       overflow,
	input  logic       clear_overflow
);

	char_word_t mem [FIFO_DEPTH];
	fifo_ptr_t  wr_ptr;
	fifo_ptr_t  rd_ptr;

	// Same index with opposite wrap bits means full
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[FIFO_ADDR_BITS] != rd_ptr[FIFO_ADDR_BITS]) &&
		(wr_ptr[FIFO_ADDR_BITS-1:0] == rd_ptr[FIFO_ADDR_BITS-1:0]);
	assign rdata = mem[rd_ptr[FIFO_ADDR_BITS-1:0]];

	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (clear_overflow)
				overflow <= 1'b0;
			// Link cannot stall, so a push into a full FIFO is lost
			if (push && full)
				overflow <= 1'b1;
			else if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge negedge_clk)
	begin
		if (push && !full)
			mem[wr_ptr[FIFO_ADDR_BITS-1:0]] <= wdata;
	end

	no_pop_when_empty_a: assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		pop |-> !empty)
		else $error("Pop on empty FIFO");

endmodule

// File: src/wb_rx_regs.sv
`timescale 1ns/1ps

module wb_rx_regs
	import spw_token_pkg::*;
	import spw_bus_pkg::*;
(
	input  logic       negedge_clk,
	input  logic       rx_resetn,
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  reg_addr_t  wb_adr,
	input  bus_word_t  wb_wdata,
	output bus_word_t  wb_rdata,
	output logic       wb_ack,
	output logic       fifo_pop,
	output logic       clear_flags,
	input  char_word_t fifo_rdata,
	input  logic       fifo_empty,
	input  logic       fifo_full,
	input  logic       overflow,
	input  logic       parity_err_flag,
	input  logic       esc_err_flag,
	input  logic       got_null,
	input  time_code_t time_value,
	input  fct_count_t fct_count
);

	logic      req;
	logic      sticky_hit;
	bus_word_t status_word;
	bus_word_t read_word;

	// New request only while ack is low
	assign req = wb_cyc && wb_stb && !wb_ack;

	// Writing a one to any sticky bit clears all three
	assign sticky_hit = wb_wdata[ST_OVERFLOW] || wb_wdata[ST_PARITY_ERR] ||
		wb_wdata[ST_ESC_ERR];

	always_comb
	begin
		status_word                = '0;
		status_word[ST_EMPTY]      = fifo_empty;
		status_word[ST_FULL]       = fifo_full;
		status_word[ST_OVERFLOW]   = overflow;
		status_word[ST_PARITY_ERR] = parity_err_flag;
		status_word[ST_ESC_ERR]    = esc_err_flag;
		status_word[ST_GOT_NULL]   = got_null;
	end

	always_comb
	begin
		case (wb_adr)
			REG_DATA:   read_word = fifo_empty ? '0 : bus_word_t'(fifo_rdata);
			REG_STATUS: read_word = status_word;
			REG_TIME:   read_word = bus_word_t'(time_value);
			default:    read_word = bus_word_t'(fct_count);
		endcase
	end

	// ------------------------------
	// Ack, read data and side effects
	// ------------------------------
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			wb_ack      <= 1'b0;
			wb_rdata    <= '0;
			fifo_pop    <= 1'b0;
			clear_flags <= 1'b0;
		end
		else
		begin
			wb_ack      <= req;
			wb_rdata    <= (req && !wb_we) ? read_word : '0;
			fifo_pop    <= req && !wb_we && (wb_adr == REG_DATA) && !fifo_empty;
			clear_flags <= req && wb_we && (wb_adr == REG_STATUS) && sticky_hit;
		end
	end

	ack_single_cycle_a: assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		wb_ack |=> !wb_ack)
		else $error("wb_ack held for more than one cycle");

endmodule

// File: src/spw_rx_top.sv
`timescale 1ns/1ps

module spw_rx_top
	import spw_token_pkg::*;
	import spw_bus_pkg::*;
(
	input  logic      negedge_clk,
	input  logic      rx_resetn,
	input  logic      rx_din,
	input  logic      rx_sin,
	input  logic      wb_cyc,
	input  logic      wb_stb,
	input  logic      wb_we,
	input  reg_addr_t wb_adr,
	input  bus_word_t wb_wdata,
	output bus_word_t wb_rdata,
	output logic      wb_ack,
	output logic      tick_out
);

	logic       bit_valid;
	logic       bit_value;
	logic       token_valid;
	logic       token_is_data;
	logic       parity_error;
	data_byte_t token_payload;
	logic       char_push;
	char_word_t char_data;
	time_code_t time_value;
	fct_count_t fct_count;
	logic       got_null;
	logic       parity_err_flag;
	logic       esc_err_flag;
	logic       clear_flags;
	logic       fifo_pop;
	char_word_t fifo_rdata;
	logic       fifo_empty;
	logic       fifo_full;
	logic       overflow;

	ds_bit_sampler u_sampler
	(
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_din      (rx_din),
		.rx_sin      (rx_sin),
		.bit_valid   (bit_valid),
		.bit_value   (bit_value)
	);

	token_deserializer u_deser
	(
		.negedge_clk   (negedge_clk),
		.rx_resetn     (rx_resetn),
		.bit_valid     (bit_valid),
		.bit_value     (bit_value),
		.token_valid   (token_valid),
		.token_is_data (token_is_data),
		.parity_error  (parity_error),
		.token_payload (token_payload)
	);

	token_classifier u_classifier
	(
		.negedge_clk     (negedge_clk),
		.rx_resetn       (rx_resetn),
		.token_valid     (token_valid),
		.token_is_data   (token_is_data),
		.parity_error    (parity_error),
		.token_payload   (token_payload),
		.char_push       (char_push),
		.char_data       (char_data),
		.tick_out        (tick_out),
		.time_value      (time_value),
		.fct_count       (fct_count),
		.got_null        (got_null),
		.parity_err_flag (parity_err_flag),
		.esc_err_flag    (esc_err_flag),
		.clear_flags     (clear_flags)
	);

	rx_fifo u_fifo
	(
		.negedge_clk    (negedge_clk),
		.rx_resetn      (rx_resetn),
		.push           (char_push),
		.pop            (fifo_pop),
		.wdata          (char_data),
		.rdata          (fifo_rdata),
		.empty          (fifo_empty),
		.full           (fifo_full),
		.overflow       (overflow),
		.clear_overflow (clear_flags)
	);

	wb_rx_regs u_regs
	(
		.negedge_clk     (negedge_clk),
		.rx_resetn       (rx_resetn),
		.wb_cyc          (wb_cyc),
		.wb_stb          (wb_stb),
		.wb_we           (wb_we),
		.wb_adr          (wb_adr),
		.wb_wdata        (wb_wdata),
		.wb_rdata        (wb_rdata),
		.wb_ack          (wb_ack),
		.fifo_pop        (fifo_pop),
		.clear_flags     (clear_flags),
		.fifo_rdata      (fifo_rdata),
		.fifo_empty      (fifo_empty),
		.fifo_full       (fifo_full),
		.overflow        (overflow),
		.parity_err_flag (parity_err_flag),
		.esc_err_flag    (esc_err_flag),
		.got_null        (got_null),
		.time_value      (time_value),
		.fct_count       (fct_count)
	);

endmodule

// File: dv/spw_rx_tb.sv
`timescale 1ns/1ps

module spw_rx_tb
	import spw_token_pkg::*;
	import spw_bus_pkg::*;
();

	localparam int CLK_PERIOD_NS = 20;
	localparam int BIT_CLKS      = 6;
	localparam int MAX_CHAR_BITS = 14;
	localparam int NUM_CHARS     = 200;
	localparam int BATCH_CHARS   = 10;
	localparam int SETTLE_CLKS   = 8;
	localparam int ACK_LIMIT     = 16;
	localparam int TIMEOUT_NS    =
		NUM_CHARS * MAX_CHAR_BITS * BIT_CLKS * CLK_PERIOD_NS + 50_000;

	// Expected FIFO words for the end markers
	localparam logic [8:0] MODEL_EOP = 9'h100;
	localparam logic [8:0] MODEL_EEP = 9'h101;

	logic       negedge_clk = 1'b0;
	logic       rx_resetn;
	logic       rx_din;
	logic       rx_sin;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	reg_addr_t  wb_adr;
	bus_word_t  wb_wdata;
	bus_word_t  wb_rdata;
	logic       wb_ack;
	logic       tick_out;

	integer     seed;
	int         checks = 0;
	int         value_errors = 0;
	int         other_errors = 0;
	int         tick_count = 0;
	int         ticks_sent = 0;
	int         n;
	logic       prev_payload_par = 1'b0;
	logic [8:0] expected_q [$];
	time_code_t last_time = '0;
	fct_count_t fct_sent = '0;

	spw_rx_top uut
	(
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_din      (rx_din),
		.rx_sin      (rx_sin),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_wdata    (wb_wdata),
		.wb_rdata    (wb_rdata),
		.wb_ack      (wb_ack),
		.tick_out    (tick_out)
	);

	always #(CLK_PERIOD_NS / 2) negedge_clk = !negedge_clk;

	// One count per time-code tick
	always @(posedge negedge_clk)
	begin
		if (tick_out === 1'b1)
			tick_count <= tick_count + 1;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the test did not finish within %0d ns", TIMEOUT_NS);
		$display("RESULT: FAIL");
		$finish;
	end

	task automatic check_value(input string name, input bus_word_t actual,
		input bus_word_t expected);
		checks++;
		if (actual !== expected)
		begin
			value_errors++;
			$display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	function automatic bus_word_t expected_status(input logic empty, input logic full,
		input logic ovf, input logic par_err, input logic esc_err, input logic null_seen);
		bus_word_t word;
		word                = '0;
		word[ST_EMPTY]      = empty;
		word[ST_FULL]       = full;
		word[ST_OVERFLOW]   = ovf;
		word[ST_PARITY_ERR] = par_err;
		word[ST_ESC_ERR]    = esc_err;
		word[ST_GOT_NULL]   = null_seen;
		return word;
	endfunction

	// ------------------------------
	// DS encoder model
	// ------------------------------

	// S toggles only when D keeps its level
	task automatic drive_bit(input logic b);
		@(posedge negedge_clk);
		if (b != rx_din)
			rx_din <= b;
		else
			rx_sin <= !rx_sin;
		repeat (BIT_CLKS - 1) @(posedge negedge_clk);
	endtask

	task automatic encode_token(input logic is_data, input data_byte_t payload,
		input logic bad_parity);
		logic flag;
		logic parity;
		int   nbits;
		int   i;
		// Flag is high for a control character
		flag   = !is_data;
		// Odd parity over previous payload, this flag and this parity bit
		parity = 1'b1 ^ prev_payload_par ^ flag ^ bad_parity;
		nbits  = is_data ? DATA_PAYLOAD_BITS : CTRL_PAYLOAD_BITS;
		drive_bit(parity);
		drive_bit(flag);
		for (i = 0; i < nbits; i++)
			drive_bit(payload[i]);
		prev_payload_par = is_data ? ^payload : ^payload[1:0];
	endtask

	task automatic emit_null();
		encode_token(1'b0, data_byte_t'(CTRL_ESC), 1'b0);
		encode_token(1'b0, data_byte_t'(CTRL_FCT), 1'b0);
	endtask

	task automatic send_random_char();
		int         kind;
		data_byte_t value;
		kind  = $unsigned($random(seed)) % 100;
		value = 8'($random(seed));
		if (kind < 50)
		begin
			encode_token(1'b1, value, 1'b0);
			expected_q.push_back({1'b0, value});
		end
		else if (kind < 60)
		begin
			encode_token(1'b0, data_byte_t'(CTRL_EOP), 1'b0);
			expected_q.push_back(MODEL_EOP);
		end
		else if (kind < 65)
		begin
			encode_token(1'b0, data_byte_t'(CTRL_EEP), 1'b0);
			expected_q.push_back(MODEL_EEP);
		end
		else if (kind < 80)
		begin
			encode_token(1'b0, data_byte_t'(CTRL_FCT), 1'b0);
			fct_sent = fct_sent + 8'd1;
		end
		else if (kind < 90)
		begin
			emit_null();
		end
		else
		begin
			// Time-code is ESC followed by a data character
			encode_token(1'b0, data_byte_t'(CTRL_ESC), 1'b0);
			encode_token(1'b1, value, 1'b0);
			last_time = value;
			ticks_sent++;
		end
	endtask

	// Covers the six-cycle pin to FIFO latency
	task automatic settle();
		repeat (SETTLE_CLKS) @(posedge negedge_clk);
	endtask

	// ------------------------------
	// Wishbone master
	// ------------------------------
	task automatic bus_transfer(input logic we, input reg_addr_t addr,
		input bus_word_t wdata, output bus_word_t rdata);
		int waited;
		rdata  = '0;
		waited = 0;
		@(posedge negedge_clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= addr;
		wb_wdata <= wdata;
		do
		begin
			@(posedge negedge_clk);
			waited++;
		end
		while (!wb_ack && waited < ACK_LIMIT);
		if (wb_ack)
			rdata = wb_rdata;
		else
		begin
			other_errors++;
			$display("No Wishbone ack within %0d cycles at address %0d", ACK_LIMIT, addr);
		end
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic drain_and_compare();
		bus_word_t  rd;
		logic [8:0] exp;
		while (expected_q.size() > 0)
		begin
			exp = expected_q.pop_front();
			bus_transfer(1'b0, REG_DATA, '0, rd);
			check_value("wb_rdata REG_DATA", rd, bus_word_t'(exp));
		end
		// Empty FIFO reads back zero
		bus_transfer(1'b0, REG_DATA, '0, rd);
		check_value("wb_rdata REG_DATA empty", rd, 16'h0000);
		bus_transfer(1'b0, REG_STATUS, '0, rd);
		check_value("wb_rdata REG_STATUS", rd,
			expected_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
		bus_transfer(1'b0, REG_TIME, '0, rd);
		check_value("wb_rdata REG_TIME", rd, bus_word_t'(last_time));
		bus_transfer(1'b0, REG_FCT_COUNT, '0, rd);
		check_value("wb_rdata REG_FCT_COUNT", rd, bus_word_t'(fct_sent));
		check_value("tick_out pulses", 16'(tick_count), 16'(ticks_sent));
	endtask

	task automatic overflow_test();
		data_byte_t value;
		bus_word_t  rd;
		int         i;
		for (i = 0; i < FIFO_DEPTH + 2; i++)
		begin
			value = 8'($random(seed));
			encode_token(1'b1, value, 1'b0);
			// Last two are dropped by the full FIFO
			if (i < FIFO_DEPTH)
				expected_q.push_back({1'b0, value});
		end
		settle();
		bus_transfer(1'b0, REG_STATUS, '0, rd);
		check_value("wb_rdata REG_STATUS full", rd,
			expected_status(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1));
		bus_transfer(1'b1, REG_STATUS, 16'(1 << ST_OVERFLOW), rd);
		bus_transfer(1'b0, REG_STATUS, '0, rd);
		check_value("wb_rdata REG_STATUS cleared", rd,
			expected_status(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
		drain_and_compare();
	endtask

	task automatic error_test();
		data_byte_t value;
		bus_word_t  rd;
		value = 8'($random(seed));
		encode_token(1'b1, value, 1'b1);
		encode_token(1'b0, data_byte_t'(CTRL_ESC), 1'b0);
		encode_token(1'b0, data_byte_t'(CTRL_EOP), 1'b0);
		settle();
		bus_transfer(1'b0, REG_STATUS, '0, rd);
		check_value("wb_rdata REG_STATUS errors", rd,
			expected_status(1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1));
		bus_transfer(1'b1, REG_STATUS, 16'((1 << ST_PARITY_ERR) | (1 << ST_ESC_ERR)), rd);
		bus_transfer(1'b0, REG_STATUS, '0, rd);
		check_value("wb_rdata REG_STATUS cleared", rd,
			expected_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial
	begin
		bus_word_t rd;
		seed = 13;
		rx_resetn <= 1'b0;
		rx_din    <= 1'b0;
		rx_sin    <= 1'b0;
		wb_cyc    <= 1'b0;
		wb_stb    <= 1'b0;
		wb_we     <= 1'b0;
		wb_adr    <= '0;
		wb_wdata  <= '0;
		repeat (4) @(posedge negedge_clk);
		rx_resetn <= 1'b1;
		repeat (2) @(posedge negedge_clk);

		bus_transfer(1'b0, REG_STATUS, '0, rd);
		check_value("wb_rdata REG_STATUS reset", rd,
			expected_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));

		emit_null();
		emit_null();
		settle();
		bus_transfer(1'b0, REG_STATUS, '0, rd);
		check_value("wb_rdata REG_STATUS null", rd,
			expected_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));

		for (n = 0; n < NUM_CHARS / 2; n++)
		begin
			send_random_char();
			if (n % BATCH_CHARS == BATCH_CHARS - 1)
			begin
				settle();
				drain_and_compare();
			end
		end

		overflow_test();
		error_test();

		// Stream continues normally after the faults
		for (n = NUM_CHARS / 2; n < NUM_CHARS; n++)
		begin
			send_random_char();
			if (n % BATCH_CHARS == BATCH_CHARS - 1)
			begin
				settle();
				drain_and_compare();
			end
		end
		settle();
		drain_and_compare();

		$display("Summary: %0d checks, %0d value errors, %0d other errors",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: project.f
src/spw_token_pkg.sv
src/spw_bus_pkg.sv
src/ds_bit_sampler.sv
src/token_deserializer.sv
src/token_classifier.sv
src/rx_fifo.sv
src/wb_rx_regs.sv
src/spw_rx_top.sv
dv/spw_rx_tb.sv

// File: Bender.yml
package:
  name: spw_rx

sources:
  - src/spw_token_pkg.sv
  - src/spw_bus_pkg.sv
  - src/ds_bit_sampler.sv
  - src/token_deserializer.sv
  - src/token_classifier.sv
  - src/rx_fifo.sv
  - src/wb_rx_regs.sv
  - src/spw_rx_top.sv
  - target: test
    files:
      - dv/spw_rx_tb.sv
